// ==== include/mem_config.svh ====
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// line and burst geometry
`define LINE_BITS 256
`define BEAT_BITS 64
// beats per line, LINE_BITS / BEAT_BITS
`define BEATS 4

// byte address width
`define ADDR_BITS 32

// direct-mapped icache geometry
`define ICACHE_SETS 8
`define ICACHE_INDEX_BITS 3

`endif

// ==== source/burst_adapter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module burst_adapter
    import mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    line_req_if.server            line,
    output logic [`ADDR_BITS-1:0] bmem_addr_o,
    output logic                  bmem_read_o,
    output logic                  bmem_write_o,
    output beat_t                 bmem_wdata_o,
    input  beat_t                 bmem_rdata_i,
    input  logic                  bmem_resp_i
);

    typedef enum logic [1:0] {BA_IDLE, BA_READ, BA_WRITE, BA_DONE} ba_state_e;

    ba_state_e             state;
    logic [1:0]            beat_cnt;
    logic [`ADDR_BITS-1:0] addr_q;
    line_t                 line_q;
    logic                  start;
    logic                  beat;
    logic                  last_beat;

    assign start     = (state == BA_IDLE) && (line.read || line.write);
    assign beat      = bmem_resp_i && ((state == BA_READ) || (state == BA_WRITE));
    assign last_beat = (beat_cnt == 2'(`BEATS - 1));

    assign bmem_addr_o  = addr_q;
    assign bmem_read_o  = (state == BA_READ);
    assign bmem_write_o = (state == BA_WRITE);
    // low beat of the shift register is the one on the bus
    assign bmem_wdata_o = line_q[`BEAT_BITS-1:0];

    assign line.resp  = (state == BA_DONE);
    assign line.rdata = line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= BA_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                BA_IDLE: begin
                    beat_cnt <= '0;
                    if (line.read) begin
                        state <= BA_READ;
                    end else if (line.write) begin
                        state <= BA_WRITE;
                    end
                end
                // memory may stall between beats, just wait
                BA_READ, BA_WRITE: begin
                    if (bmem_resp_i) begin
                        beat_cnt <= beat_cnt + 2'd1;
                        if (last_beat) begin
                            state <= BA_DONE;
                        end
                    end
                end
                BA_DONE: state <= BA_IDLE;
                default: state <= BA_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            // clear the in-line offset bits
            addr_q <= line.address.flat & ~`ADDR_BITS'(`LINE_BITS / 8 - 1);
            line_q <= line.wdata;
        end else if (beat) begin
            if (state == BA_READ) begin
                // beat k ends up at bits 64k after four shifts
                line_q <= {bmem_rdata_i, line_q[`LINE_BITS-1:`BEAT_BITS]};
            end else begin
                line_q <= line_q >> `BEAT_BITS;
            end
        end
    end

    // requester lets go the cycle after resp
    a_req_drop: assert property (@(posedge clk) disable iff (rst)
        line.resp |=> !(line.read || line.write));

endmodule

`default_nettype wire

// ==== source/icache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module icache
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cache_en_i,
    input  logic        flush_i,
    input  logic        read_i,
    input  addr_u       addr_i,
    output logic [31:0] rdata_o,
    output logic        resp_o,
    output logic        hit_o,
    output logic        miss_o,
    line_req_if.client  mem
);

    typedef enum logic [1:0] {IC_IDLE, IC_FETCH, IC_RESP} ic_state_e;

    ic_state_e                state;
    logic [`ICACHE_SETS-1:0] valid;
    tag_t                     tag_arr  [`ICACHE_SETS];
    line_t                    data_arr [`ICACHE_SETS];
    addr_u                    req_q;
    logic                     was_hit;
    logic                     hit;
    logic                     accept;
    logic                     fetch_done;

    // lookup straight off the incoming address
    assign hit = cache_en_i && valid[addr_i.f.index] &&
                 (tag_arr[addr_i.f.index] == addr_i.f.tag);
    assign accept     = (state == IC_IDLE) && read_i;
    assign fetch_done = (state == IC_FETCH) && mem.resp;

    // read-only side, adapter aligns the address
    assign mem.read    = (state == IC_FETCH);
    assign mem.write   = 1'b0;
    assign mem.address = req_q;
    assign mem.wdata   = '0;

    assign resp_o = (state == IC_RESP);
    assign hit_o  = resp_o && was_hit;
    // bypass fetches land here too
    assign miss_o = resp_o && !was_hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IC_IDLE;
            valid <= '0;
        end else begin
            case (state)
                IC_IDLE: begin
                    if (read_i) begin
                        state <= hit ? IC_RESP : IC_FETCH;
                    end
                end
                IC_FETCH: begin
                    if (mem.resp) begin
                        state <= IC_RESP;
                    end
                end
                // resp cycle, request is still up so ignore it
                IC_RESP: state <= IC_IDLE;
                default: state <= IC_IDLE;
            endcase
            // flush wins over a fill in the same cycle
            if (flush_i) begin
                valid <= '0;
            end else if (fetch_done && cache_en_i) begin
                valid[req_q.f.index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q   <= addr_i;
            was_hit <= hit;
            rdata_o <= data_arr[addr_i.f.index][addr_i.f.word*32 +: 32];
        end
        if (fetch_done) begin
            rdata_o <= mem.rdata[req_q.f.word*32 +: 32];
        end
        // line fill only with the cache on
        if (fetch_done && cache_en_i) begin
            tag_arr[req_q.f.index]  <= req_q.f.tag;
            data_arr[req_q.f.index] <= mem.rdata;
        end
    end

    // a line only comes back while a fetch is out
    a_resp_in_fetch: assert property (@(posedge clk) disable iff (rst)
        mem.resp |-> (state == IC_FETCH));

endmodule

`default_nettype wire

// ==== source/line_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_arbiter (
    input  logic       clk,
    input  logic       rst,
    line_req_if.server ic,
    line_req_if.server dc,
    line_req_if.client mem
);

    typedef enum logic [1:0] {ARB_IDLE, ARB_IC, ARB_DC, ARB_GAP} arb_state_e;

    arb_state_e state;
    logic       ic_req;
    logic       dc_req;
    logic       sel_ic;
    logic       sel_dc;

    assign ic_req = ic.read | ic.write;
    assign dc_req = dc.read | dc.write;

    // grant in the idle cycle itself, data side first
    assign sel_dc = (state == ARB_DC) || ((state == ARB_IDLE) && dc_req);
    assign sel_ic = (state == ARB_IC) || ((state == ARB_IDLE) && !dc_req && ic_req);

    always_comb begin
        mem.read    = 1'b0;
        mem.write   = 1'b0;
        mem.address = ic.address;
        mem.wdata   = ic.wdata;
        if (sel_dc) begin
            mem.read    = dc.read;
            mem.write   = dc.write;
            mem.address = dc.address;
            mem.wdata   = dc.wdata;
        end else if (sel_ic) begin
            mem.read  = ic.read;
            mem.write = ic.write;
        end
    end

    // response goes to the owner only
    assign ic.resp  = sel_ic && mem.resp;
    assign dc.resp  = sel_dc && mem.resp;
    assign ic.rdata = sel_ic ? mem.rdata : '0;
    assign dc.rdata = sel_dc ? mem.rdata : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ARB_IDLE;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (dc_req) begin
                        state <= ARB_DC;
                    end else if (ic_req) begin
                        state <= ARB_IC;
                    end
                end
                ARB_IC, ARB_DC: begin
                    if (mem.resp) begin
                        state <= ARB_GAP;
                    end
                end
                // owner drops its request here
                ARB_GAP: state <= ARB_IDLE;
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // owner keeps its request up until the adapter answers
    a_req_held: assert property (@(posedge clk) disable iff (rst)
        ((state == ARB_IC) || (state == ARB_DC)) && !mem.resp |-> (mem.read || mem.write));

endmodule

`default_nettype wire

// ==== source/line_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface line_req_if
    import mem_pkg::*;
();

    logic  read;
    logic  write;
    addr_u address;
    line_t wdata;
    line_t rdata;
    // one-cycle pulse, request drops the cycle after
    logic  resp;

    modport client (
        output read, write, address, wdata,
        input  rdata, resp
    );

    modport server (
        input  read, write, address, wdata,
        output rdata, resp
    );

endinterface

`default_nettype wire

// ==== source/mem_ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_regs
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  reg_off_e    wb_adr_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,
    output logic        cache_en_o,
    output logic        flush_o,
    input  logic        hit_i,
    input  logic        miss_i
);

    logic [31:0] hits;
    logic [31:0] misses;
    logic        wb_valid;
    logic        wb_wr;

    // a cycle counts once, not again while ack is up
    assign wb_valid = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign wb_wr    = wb_valid && wb_we_i;

    // flush strobe straight from the write, never stored
    assign flush_o = wb_wr && (wb_adr_i == REG_CTRL) && wb_dat_i[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack_o   <= 1'b0;
            cache_en_o <= 1'b1;
            hits       <= '0;
            misses     <= '0;
        end else begin
            wb_ack_o <= wb_valid;
            if (hit_i) begin
                hits <= hits + 32'd1;
            end
            if (miss_i) begin
                misses <= misses + 32'd1;
            end
            // a write to a counter clears it, data ignored
            if (wb_wr) begin
                case (wb_adr_i)
                    REG_CTRL:   cache_en_o <= wb_dat_i[0];
                    REG_HITS:   hits       <= '0;
                    REG_MISSES: misses     <= '0;
                    default:    ;
                endcase
            end
        end
    end

    // read data lines up with ack
    always_ff @(posedge clk) begin
        if (wb_valid) begin
            case (wb_adr_i)
                REG_CTRL:   wb_dat_o <= {31'd0, cache_en_o};
                REG_HITS:   wb_dat_o <= hits;
                REG_MISSES: wb_dat_o <= misses;
                default:    wb_dat_o <= '0;
            endcase
        end
    end

    // a fetch ends as a hit or a miss, never both
    a_hit_miss_excl: assert property (@(posedge clk) disable iff (rst) !(hit_i && miss_i));

endmodule

`default_nettype wire

// ==== source/mem_pkg.sv ====
`default_nettype none

`include "mem_config.svh"

package mem_pkg;

    typedef logic [`LINE_BITS-1:0] line_t;
    typedef logic [`BEAT_BITS-1:0] beat_t;

    // tag is what is left above index, word and byte offsets
    typedef logic [`ADDR_BITS-`ICACHE_INDEX_BITS-6:0] tag_t;

    typedef struct packed {
        tag_t                          tag;
        logic [`ICACHE_INDEX_BITS-1:0] index;
        // 32-bit word within the line
        logic [2:0]                    word;
        logic [1:0]                    byte_off;
    } addr_fields_t;

    // same address word, flat or split into cache fields
    typedef union packed {
        logic [`ADDR_BITS-1:0] flat;
        addr_fields_t          f;
    } addr_u;

    // register word offsets on the wishbone side
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,
        REG_HITS   = 2'd1,
        REG_MISSES = 2'd2
    } reg_off_e;

endpackage

`default_nettype wire

// ==== source/mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_subsystem
    import mem_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    // fetch port
    input  logic                         imem_read_i,
    input  logic [`ADDR_BITS-1:0]        imem_addr_i,
    output logic [31:0]                  imem_rdata_o,
    output logic                         imem_resp_o,
    // data line port
    input  logic                         dline_read_i,
    input  logic                         dline_write_i,
    input  logic [`ADDR_BITS-1:0]        dline_addr_i,
    input  logic [`LINE_BITS-1:0]        dline_wdata_i,
    output logic [`LINE_BITS-1:0]        dline_rdata_o,
    output logic                         dline_resp_o,
    // burst memory
    output logic [`ADDR_BITS-1:0]        bmem_addr_o,
    output logic                         bmem_read_o,
    output logic                         bmem_write_o,
    output logic [`BEAT_BITS-1:0]        bmem_wdata_o,
    input  logic [`BEAT_BITS-1:0]        bmem_rdata_i,
    input  logic                         bmem_resp_i,
    // wishbone register port
    input  logic                         wb_cyc_i,
    input  logic                         wb_stb_i,
    input  logic                         wb_we_i,
    input  logic [$bits(reg_off_e)-1:0]  wb_adr_i,
    input  logic [31:0]                  wb_dat_i,
    output logic [31:0]                  wb_dat_o,
    output logic                         wb_ack_o
);

    logic cache_en;
    logic flush;
    logic hit;
    logic miss;

    line_req_if ic_if ();
    line_req_if dc_if ();
    line_req_if bm_if ();

    // data port enters as a client of the arbiter
    assign dc_if.read    = dline_read_i;
    assign dc_if.write   = dline_write_i;
    assign dc_if.address = dline_addr_i;
    assign dc_if.wdata   = dline_wdata_i;
    assign dline_rdata_o = dc_if.rdata;
    assign dline_resp_o  = dc_if.resp;

    mem_ctrl_regs regs_inst (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (reg_off_e'(wb_adr_i)),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .cache_en_o (cache_en),
        .flush_o    (flush),
        .hit_i      (hit),
        .miss_i     (miss)
    );

    icache icache_inst (
        .clk        (clk),
        .rst        (rst),
        .cache_en_i (cache_en),
        .flush_i    (flush),
        .read_i     (imem_read_i),
        .addr_i     (imem_addr_i),
        .rdata_o    (imem_rdata_o),
        .resp_o     (imem_resp_o),
        .hit_o      (hit),
        .miss_o     (miss),
        .mem        (ic_if.client)
    );

    line_arbiter arbiter_inst (
        .clk (clk),
        .rst (rst),
        .ic  (ic_if.server),
        .dc  (dc_if.server),
        .mem (bm_if.client)
    );

    burst_adapter adapter_inst (
        .clk          (clk),
        .rst          (rst),
        .line         (bm_if.server),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .bmem_write_o (bmem_write_o),
        .bmem_wdata_o (bmem_wdata_o),
        .bmem_rdata_i (bmem_rdata_i),
        .bmem_resp_i  (bmem_resp_i)
    );

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
source/mem_pkg.sv
source/line_req_if.sv
source/icache.sv
source/line_arbiter.sv
source/burst_adapter.sv
source/mem_ctrl_regs.sv
source/mem_subsystem.sv
test/mem_subsystem_tb.sv

// ==== test/mem_subsystem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_subsystem_tb
    import mem_pkg::*;
();

    localparam int NUM_TESTS = 5;
    localparam int TEST_NS   = 20000;
    localparam int MEM_BEATS = 1024;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  imem_read_i;
    logic [`ADDR_BITS-1:0] imem_addr_i;
    logic [31:0]           imem_rdata_o;
    logic                  imem_resp_o;
    logic                  dline_read_i;
    logic                  dline_write_i;
    logic [`ADDR_BITS-1:0] dline_addr_i;
    line_t                 dline_wdata_i;
    line_t                 dline_rdata_o;
    logic                  dline_resp_o;
    logic [`ADDR_BITS-1:0] bmem_addr_o;
    logic                  bmem_read_o;
    logic                  bmem_write_o;
    beat_t                 bmem_wdata_o;
    beat_t                 bmem_rdata_i;
    logic                  bmem_resp_i;
    logic                  wb_cyc_i;
    logic                  wb_stb_i;
    logic                  wb_we_i;
    reg_off_e              wb_adr;
    logic [31:0]           wb_dat_i;
    logic [31:0]           wb_dat_o;
    logic                  wb_ack_o;

    // burst memory model state
    beat_t       mem_arr [MEM_BEATS];
    logic [1:0]  mdl_beat;
    logic [9:0]  mdl_idx;
    logic [31:0] burst_addr;
    int          rd_bursts;
    int          wr_bursts;
    integer      seed;

    mem_subsystem mem_subsystem_inst (
        .clk           (clk),
        .rst           (rst),
        .imem_read_i   (imem_read_i),
        .imem_addr_i   (imem_addr_i),
        .imem_rdata_o  (imem_rdata_o),
        .imem_resp_o   (imem_resp_o),
        .dline_read_i  (dline_read_i),
        .dline_write_i (dline_write_i),
        .dline_addr_i  (dline_addr_i),
        .dline_wdata_i (dline_wdata_i),
        .dline_rdata_o (dline_rdata_o),
        .dline_resp_o  (dline_resp_o),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_write_o  (bmem_write_o),
        .bmem_wdata_o  (bmem_wdata_o),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_resp_i   (bmem_resp_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o)
    );

    always #50 clk = ~clk;

    // odd multiplier, so every address bit changes the word
    function automatic logic [31:0] pattern_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5ee1_c0de;
    endfunction

    // little-endian words, word w at bits 32w
    function automatic line_t pattern_line(input logic [31:0] addr);
        line_t l;
        for (int w = 0; w < 8; w++) begin
            l[w*32 +: 32] = pattern_word({addr[31:5], 5'd0} + 32'(w * 4));
        end
        return l;
    endfunction

    function automatic line_t model_line(input logic [31:0] addr);
        line_t l;
        for (int k = 0; k < `BEATS; k++) begin
            l[k*64 +: 64] = mem_arr[10'(addr >> 3) + 10'(k)];
        end
        return l;
    endfunction

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_line(input string what, input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    // one beat per resp pulse, resp low between beats
    always @(negedge clk) begin
        if (rst) begin
            bmem_resp_i = 1'b0;
            mdl_beat    = 2'd0;
        end else if (bmem_resp_i) begin
            bmem_resp_i = 1'b0;
        end else if (bmem_read_o || bmem_write_o) begin
            mdl_idx = 10'(bmem_addr_o >> 3) + 10'(mdl_beat);
            // address of the burst as it starts
            if (mdl_beat == 2'd0) begin
                burst_addr = bmem_addr_o;
            end
            if (bmem_read_o) begin
                bmem_rdata_i = mem_arr[mdl_idx];
                if (mdl_beat == 2'd0) begin
                    rd_bursts++;
                end
            end else begin
                mem_arr[mdl_idx] = bmem_wdata_o;
                if (mdl_beat == 2'd0) begin
                    wr_bursts++;
                end
            end
            // wraps to 0 after the fourth beat
            mdl_beat    = mdl_beat + 2'd1;
            bmem_resp_i = 1'b1;
        end
    end

    task automatic wb_access(input reg_off_e off, input logic we, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        @(negedge clk);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr   = off;
        wb_dat_i = wdat;
        @(negedge clk);
        while (!wb_ack_o) begin
            @(negedge clk);
        end
        rdat     = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic reg_write(input reg_off_e off, input logic [31:0] data);
        logic [31:0] unused;
        wb_access(off, 1'b1, data, unused);
    endtask

    task automatic reg_read(input reg_off_e off, output logic [31:0] data);
        wb_access(off, 1'b0, 32'd0, data);
    endtask

    task automatic clear_counters();
        reg_write(REG_HITS, 32'd0);
        reg_write(REG_MISSES, 32'd0);
    endtask

    task automatic check_counters(input logic [31:0] hits, input logic [31:0] misses);
        logic [31:0] val;
        reg_read(REG_HITS, val);
        check_count("hit counter", val, hits);
        reg_read(REG_MISSES, val);
        check_count("miss counter", val, misses);
    endtask

    // cycles counts falling edges until resp is seen
    task automatic fetch(input logic [31:0] addr, output logic [31:0] word,
                         output int cycles);
        @(negedge clk);
        imem_read_i = 1'b1;
        imem_addr_i = addr;
        @(negedge clk);
        cycles = 1;
        while (!imem_resp_o) begin
            @(negedge clk);
            cycles++;
        end
        word        = imem_rdata_o;
        imem_read_i = 1'b0;
    endtask

    task automatic line_access(input logic we, input logic [31:0] addr, input line_t wdata,
                               output line_t rline);
        @(negedge clk);
        dline_read_i  = !we;
        dline_write_i = we;
        dline_addr_i  = addr;
        dline_wdata_i = wdata;
        @(negedge clk);
        while (!dline_resp_o) begin
            @(negedge clk);
        end
        rline         = dline_rdata_o;
        dline_read_i  = 1'b0;
        dline_write_i = 1'b0;
    endtask

    task automatic test_reset_state();
        logic [31:0] val;
        check_word("idle outputs", {27'd0, imem_resp_o, dline_resp_o, bmem_read_o,
                                    bmem_write_o, wb_ack_o}, 32'd0);
        reg_read(REG_CTRL, val);
        check_word("ctrl after reset", val, 32'd1);
        check_counters(32'd0, 32'd0);
        check_count("bursts after reset", 32'(rd_bursts + wr_bursts), 32'd0);
    endtask

    task automatic test_miss_then_hit();
        logic [31:0] word;
        int          cycles;
        int          bursts;
        fetch(32'h0000_0040, word, cycles);
        check_word("miss fetch word", word, pattern_word(32'h0000_0040));
        check_count("bursts on miss", 32'(rd_bursts), 32'd1);
        check_word("miss burst address", burst_addr, 32'h0000_0040);
        bursts = rd_bursts;
        // same line, other word
        fetch(32'h0000_004c, word, cycles);
        check_word("hit fetch word", word, pattern_word(32'h0000_004c));
        check_count("hit latency", 32'(cycles), 32'd1);
        check_count("bursts on hit", 32'(rd_bursts), 32'(bursts));
        check_counters(32'd1, 32'd1);
    endtask

    task automatic test_line_write_read();
        line_t       wline;
        line_t       rline;
        logic [31:0] word;
        logic [31:0] val;
        int          cycles;
        for (int w = 0; w < 8; w++) begin
            wline[w*32 +: 32] = $random(seed);
        end
        clear_counters();
        // cache the old line first so the flush matters
        fetch(32'h0000_0104, word, cycles);
        check_word("old fetch word", word, pattern_word(32'h0000_0104));
        line_access(1'b1, 32'h0000_0100, wline, rline);
        check_count("write bursts", 32'(wr_bursts), 32'd1);
        check_word("write burst address", burst_addr, 32'h0000_0100);
        check_line("model after line write", model_line(32'h0000_0100), wline);
        line_access(1'b0, 32'h0000_0100, '0, rline);
        check_line("line read back", rline, wline);
        // keep enable, pulse flush
        reg_write(REG_CTRL, 32'h0000_0003);
        reg_read(REG_CTRL, val);
        check_word("ctrl after flush", val, 32'd1);
        fetch(32'h0000_0104, word, cycles);
        check_word("fetch after flush", word, wline[63:32]);
        check_counters(32'd0, 32'd2);
    endtask

    task automatic test_bypass();
        logic [31:0] word;
        int          cycles;
        int          bursts;
        // line is cached, only the cleared enable keeps it from hitting
        fetch(32'h0000_0044, word, cycles);
        check_word("cached fetch word", word, pattern_word(32'h0000_0044));
        reg_write(REG_CTRL, 32'd0);
        clear_counters();
        bursts = rd_bursts;
        for (int i = 0; i < 3; i++) begin
            fetch(32'h0000_0044, word, cycles);
            check_word("bypass fetch word", word, pattern_word(32'h0000_0044));
            check_word("bypass burst address", burst_addr, 32'h0000_0040);
            check_count("bypass bursts", 32'(rd_bursts), 32'(bursts + i + 1));
        end
        check_counters(32'd0, 32'd3);
        reg_write(REG_CTRL, 32'd1);
    endtask

    task automatic test_concurrent();
        logic [31:0] word;
        line_t       rline;
        time         ic_t;
        time         dc_t;
        @(negedge clk);
        imem_read_i  = 1'b1;
        imem_addr_i  = 32'h0000_0208;
        dline_read_i = 1'b1;
        dline_addr_i = 32'h0000_0300;
        fork
            begin
                @(negedge clk);
                while (!imem_resp_o) begin
                    @(negedge clk);
                end
                word        = imem_rdata_o;
                ic_t        = $time;
                imem_read_i = 1'b0;
            end
            begin
                @(negedge clk);
                while (!dline_resp_o) begin
                    @(negedge clk);
                end
                rline        = dline_rdata_o;
                dc_t         = $time;
                dline_read_i = 1'b0;
            end
        join
        check_word("concurrent fetch word", word, pattern_word(32'h0000_0208));
        check_line("concurrent line read", rline, pattern_line(32'h0000_0300));
        if (dc_t >= ic_t) begin
            $display("The fetch finished before the data line read, data priority broken");
            abort_run();
        end
    endtask

    initial begin
        seed = 45;
        for (int i = 0; i < MEM_BEATS; i++) begin
            mem_arr[i] = {pattern_word(32'(i * 8 + 4)), pattern_word(32'(i * 8))};
        end
    end

    // watchdog
    initial begin
        #(NUM_TESTS * TEST_NS);
        $display("Timeout after %0d ns, the tests did not finish", NUM_TESTS * TEST_NS);
        abort_run();
    end

    initial begin
        rst           = 1'b1;
        imem_read_i   = 1'b0;
        imem_addr_i   = '0;
        dline_read_i  = 1'b0;
        dline_write_i = 1'b0;
        dline_addr_i  = '0;
        dline_wdata_i = '0;
        bmem_rdata_i  = '0;
        bmem_resp_i   = 1'b0;
        wb_cyc_i      = 1'b0;
        wb_stb_i      = 1'b0;
        wb_we_i       = 1'b0;
        wb_adr        = REG_CTRL;
        wb_dat_i      = '0;
        rd_bursts     = 0;
        wr_bursts     = 0;
        burst_addr    = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_miss_then_hit();
        test_line_write_read();
        test_bypass();
        test_concurrent();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
